/* Makefile */
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir obj_dir \
		--top-module sensor_core_tb -f filelist.f -o sim

run: build
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module sensor_core -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* ads1292/ads1292_engine.sv */
`default_nettype none

module ads1292_engine (
	input wire i_CLK,
	input wire i_RST,
	sensor_ctrl_if.engine ctrl,
	input wire sensor_pkg::sample_t i_data_out, // streamed sample
	input wire i_data_valid, // held until ack
	input wire i_busy,
	output logic o_data_ack,
	output sensor_pkg::ads_ctrl_t o_control,
	output sensor_pkg::byte_t o_reg_addr,
	output sensor_pkg::byte_t o_data_in,
	output sensor_pkg::sample_t o_sample,
	output logic o_sample_strobe
);
	import sensor_pkg::*;

	ads_state_t r_state;
	logic [3:0] r_idx; // init table position

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= ADS_ST_IDLE;
			r_idx <= '0;
			o_data_ack <= 1'b0;
			o_control <= ADS_CB_IDLE;
			o_reg_addr <= '0;
			o_data_in <= '0;
			o_sample <= '0;
			o_sample_strobe <= 1'b0;
			ctrl.chip_set_done <= 1'b0;
			ctrl.run_set_done <= 1'b0;
		end else begin
			case (r_state)
				ADS_ST_IDLE: begin
					if (ctrl.chip_set && !ctrl.chip_set_done) begin
						r_idx <= '0;
						r_state <= ADS_ST_SETTING;
					end else if (ctrl.run_set && !ctrl.run_set_done) begin
						o_control <= ADS_CB_RDATAC; // enter continuous read
						ctrl.run_set_done <= 1'b1;
						r_state <= ADS_ST_STREAM;
					end
				end

				// ==================================================
				// register writes
				// ==================================================
				ADS_ST_SETTING: begin
					if (r_idx == 4'(ADS_INIT_LEN)) begin
						ctrl.chip_set_done <= 1'b1;
						r_state <= ADS_ST_IDLE;
					end else begin
						o_control <= ADS_CB_WREG;
						o_reg_addr <= ADS_INIT_TABLE[r_idx].addr;
						o_data_in <= ADS_INIT_TABLE[r_idx].data;
						r_idx <= r_idx + 4'd1;
						r_state <= ADS_ST_WREG;
					end
				end
				ADS_ST_WREG: begin
					o_control <= ADS_CB_DUMMY; // wreg held one cycle
					r_state <= ADS_ST_WAIT;
				end
				ADS_ST_WAIT: begin
					if (!i_busy) r_state <= ADS_ST_SETTING;
				end

				// ==================================================
				// rdatac streaming
				// ==================================================
				ADS_ST_STREAM: begin
					o_control <= ADS_CB_DUMMY;
					if (!ctrl.run_set) begin
						o_control <= ADS_CB_SDATAC;
						ctrl.run_set_done <= 1'b0;
						r_state <= ADS_ST_STOP;
					end else if (i_data_valid) begin
						o_sample <= i_data_out; // capture
						o_sample_strobe <= 1'b1;
						r_state <= ADS_ST_ACK;
					end
				end
				ADS_ST_ACK: begin
					o_sample_strobe <= 1'b0;
					o_data_ack <= 1'b1; // cycle after capture
					r_state <= ADS_ST_RELEASE;
				end
				ADS_ST_RELEASE: begin
					o_data_ack <= 1'b0; // let valid fall before next look
					r_state <= ADS_ST_STREAM;
				end
				ADS_ST_STOP: begin
					o_control <= ADS_CB_DUMMY; // sdatac was one cycle
					r_state <= ADS_ST_IDLE;
				end
				default: r_state <= ADS_ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* common/sensor_ctrl_if.sv */
`default_nettype none

// per-chip sequencing handshake, all level based
interface sensor_ctrl_if;
	logic chip_set; // request config sequence
	logic chip_set_done; // sticky until reset
	logic run_set; // high = run, low = stop
	logic run_set_done; // chip in its run state

	modport seq (
		output chip_set,
		output run_set,
		input chip_set_done,
		input run_set_done
	);

	modport engine (
		input chip_set,
		input run_set,
		output chip_set_done,
		output run_set_done
	);
endinterface

`default_nettype wire

/* common/sensor_pkg.sv */
`default_nettype none

package sensor_pkg;

	// ==========================================================
	// words and records
	// ==========================================================
	typedef logic [7:0] byte_t; // reg addr, reg data or host cmd
	typedef logic [23:0] sample_t; // filtered ads1292 sample
	typedef logic [11:0] touch_t; // ele0 .. ele11
	typedef logic [55:0] tx_frame_t; // 7 bytes toward the host

	// one config table entry
	typedef struct packed {
		byte_t addr;
		byte_t data;
	} reg_write_t;

	typedef enum logic [7:0] {
		HOST_CMD_RUN = 8'h52, // 'R'
		HOST_CMD_STOP = 8'h53 // 'S'
	} host_cmd_t;

	// ads1292 bus controller opcodes
	typedef enum logic [2:0] {
		ADS_CB_IDLE = 3'b000,
		ADS_CB_SYSCMD = 3'b001,
		ADS_CB_WREG = 3'b010,
		ADS_CB_RREG = 3'b011,
		ADS_CB_RDATAC = 3'b100,
		ADS_CB_SDATAC = 3'b101,
		ADS_CB_DUMMY = 3'b111 // nothing to do
	} ads_ctrl_t;

	typedef enum logic [2:0] {
		CORE_ST_IDLE, CORE_ST_WAIT_INIT, CORE_ST_CHIP_SET,
		CORE_ST_STANDBY, CORE_ST_READING
	} core_state_t;

	typedef enum logic [3:0] {
		MPR_ST_IDLE, MPR_ST_SETTING, MPR_ST_RUN, MPR_ST_RUN_DONE,
		MPR_ST_STOP, MPR_ST_STOP_DONE, MPR_ST_POLL, MPR_ST_POLL_HI,
		MPR_ST_ISSUE, MPR_ST_XFER, MPR_ST_SKIP, MPR_ST_WAIT, MPR_ST_GAP
	} mpr_state_t;

	typedef enum logic [2:0] {
		ADS_ST_IDLE, ADS_ST_SETTING, ADS_ST_WREG, ADS_ST_WAIT,
		ADS_ST_STREAM, ADS_ST_ACK, ADS_ST_RELEASE, ADS_ST_STOP
	} ads_state_t;

	// ==========================================================
	// constants
	// ==========================================================
	localparam byte_t FRAME_ADS_MARK = 8'hAA; // leads the frame
	localparam byte_t FRAME_MPR_MARK = 8'hBB; // closes the frame

	localparam byte_t MPR_ELE_CONFIG_REG = 8'h5E;
	localparam byte_t MPR_ELE_RUN = 8'h8F; // all 12 electrodes on
	localparam byte_t MPR_ELE_STOP = 8'h00;
	localparam byte_t MPR_STATUS0_REG = 8'h00; // ele0..7
	localparam byte_t MPR_STATUS1_REG = 8'h01; // ele8..11 in low nibble

	localparam int MPR_INIT_LEN = 14;
	localparam int ADS_INIT_LEN = 11;

	// baseline filter setup, rising / falling / touched, then debounce and cdc
	localparam reg_write_t MPR_INIT_TABLE [MPR_INIT_LEN] = '{
		'{8'h2B, 8'h01}, '{8'h2C, 8'h01}, '{8'h2D, 8'h0E}, '{8'h2E, 8'h00},
		'{8'h2F, 8'h01}, '{8'h30, 8'h05}, '{8'h31, 8'h01}, '{8'h32, 8'h00},
		'{8'h33, 8'h00}, '{8'h34, 8'h00}, '{8'h35, 8'h00}, '{8'h5B, 8'h00},
		'{8'h5C, 8'h10}, '{8'h5D, 8'h20}
	};

	// resp regs first since they reset the digital filter
	localparam reg_write_t ADS_INIT_TABLE [ADS_INIT_LEN] = '{
		'{8'h09, 8'h02}, // resp1
		'{8'h0A, 8'h87}, // resp2, bit2 must be 1
		'{8'h01, 8'h01}, // config1
		'{8'h02, 8'hE0}, // config2
		'{8'h03, 8'h10}, // loff
		'{8'h04, 8'h00}, // ch1set
		'{8'h05, 8'h00}, // ch2set
		'{8'h06, 8'h2C}, // rld_sens
		'{8'h07, 8'h0E}, // loff_sens
		'{8'h08, 8'h40}, // loff_stat
		'{8'h0B, 8'h00} // gpio
	};

endpackage

`default_nettype wire

/* dv/sensor_core_chk.sv */
`default_nettype none

module sensor_core_chk (
	input wire i_CLK,
	input wire i_RST,
	input wire i_write_enable, // mpr121 bus
	input wire i_read_enable,
	input wire i_tx_valid, // host uart
	input wire i_strobe, // new sample into the frame buffer
	input wire i_ack, // ads1292 sample stream
	input wire i_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0; // failed assertions so far

	// ==========================================================
	// mpr121 bus enables
	// ==========================================================
	a_single_access: assert property (@(posedge i_CLK) disable iff (i_RST)
		!(i_write_enable && i_read_enable))
		else begin
			fail_count++;
			$error("mpr121 write and read enable high together");
		end

	a_write_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_write_enable |=> !i_write_enable)
		else begin
			fail_count++;
			$error("mpr121 write enable longer than one cycle");
		end

	a_read_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_read_enable |=> !i_read_enable)
		else begin
			fail_count++;
			$error("mpr121 read enable longer than one cycle");
		end

	// ==========================================================
	// host and sample handshakes
	// ==========================================================
	a_tx_one_beat: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_tx_valid && !i_strobe |=> !i_tx_valid) // one beat per frame
		else begin
			fail_count++;
			$error("tx valid held with no new frame behind it");
		end

	a_ack_after_valid: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_ack |-> $past(i_valid)) // ack answers a held sample
		else begin
			fail_count++;
			$error("sample ack without valid in the cycle before");
		end

endmodule

`default_nettype wire

/* dv/sensor_core_tb.sv */
`default_nettype none

module sensor_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import sensor_pkg::*;

	localparam int N_SAMPLES = 6; // free stream phase
	localparam int N_HELD = 3; // samples under back-pressure
	localparam int CFG_CYCLES = MPR_INIT_LEN * 8 + ADS_INIT_LEN * 5;
	localparam int RUN_CYCLES = 80; // run write, rdatac, two poll rounds
	localparam int STREAM_CYCLES = (N_SAMPLES + N_HELD) * 12;
	localparam int STOP_CYCLES = 60;
	localparam int FAIL_CYCLES = 100;
	localparam int LIMIT_CYCLES = 3 * (CFG_CYCLES + 2 * RUN_CYCLES + STREAM_CYCLES
		+ STOP_CYCLES + FAIL_CYCLES) + 200;

	localparam byte_t ST0 = 8'h5A; // model status 0, ele0..7
	localparam byte_t ST1 = 8'hC3; // model status 1, only low nibble counts

	logic i_CLK;
	logic i_RST;
	logic [15:0] i_uart_data_rx;
	logic i_uart_data_rx_valid;
	logic i_uart_data_tx_ready;
	tx_frame_t o_uart_data_tx;
	logic o_uart_data_tx_valid;
	byte_t i_mpr121_data_out = '0;
	byte_t o_mpr121_reg_addr;
	byte_t o_mpr121_data_in;
	logic o_mpr121_write_enable;
	logic o_mpr121_read_enable;
	logic i_mpr121_init_set;
	logic i_mpr121_busy = 1'b0;
	logic i_mpr121_fail = 1'b0;
	touch_t o_mpr121_touch_status;
	logic o_mpr121_error;
	sample_t i_ads1292_data_out = '0;
	logic i_ads1292_data_valid = 1'b0;
	logic o_ads1292_data_ack;
	ads_ctrl_t o_ads1292_control;
	byte_t o_ads1292_reg_addr;
	byte_t o_ads1292_data_in;
	logic i_ads1292_init_set;
	logic i_ads1292_busy = 1'b0;
	logic o_chip_set;
	logic o_run_set;

	// chip model state
	reg_write_t mpr_log[$]; // every mpr121 write
	reg_write_t ads_log[$]; // every wreg access
	sample_t ads_offer[$]; // samples waiting to be offered
	ads_ctrl_t ads_last_cmd = ADS_CB_IDLE;
	sample_t last_acked = '0;
	int unsigned acked_count = 0;
	int unsigned hi_reads = 0; // status 1 reads seen
	int mpr_busy_cnt = 0;
	int ads_busy_cnt = 0;
	logic fail_arm; // fail every following read

	int unsigned frames_seen = 0;
	tx_frame_t last_frame = '0;
	logic [15:0] lfsr;

	sensor_core #(.POLL_GAP(1)) i_dut (.*);

	bind sensor_core sensor_core_chk u_chk (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_write_enable(o_mpr121_write_enable),
		.i_read_enable(o_mpr121_read_enable),
		.i_tx_valid(o_uart_data_tx_valid),
		.i_strobe(w_sample_strobe),
		.i_ack(o_ads1292_data_ack),
		.i_valid(i_ads1292_data_valid)
	);

	// ==========================================================
	// helpers and reference
	// ==========================================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // taps 16 14 13 11
	endfunction

	task automatic draw_sample(output sample_t s);
		s = '0;
		for (int i = 0; i < 24; i++) begin
			s = {s[22:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// marker, sample, zero nibble, touch bits, marker
	function automatic tx_frame_t expected_frame(input sample_t s, input byte_t st0,
		input byte_t st1);
		return {8'hAA, s, 4'h0, st1[3:0], st0, 8'hBB};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_frame(input tx_frame_t got, input tx_frame_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: frame %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_touch(input touch_t got, input touch_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: touch status %h, expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_write(input reg_write_t got, input reg_write_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: write %h <= %h, expected %h <= %h",
				$time, got.addr, got.data, exp.addr, exp.data));
		end
	endtask

	task automatic check_ctrl(input ads_ctrl_t got, input ads_ctrl_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: ads1292 control %s, expected %s",
				$time, got.name(), exp.name()));
		end
	endtask

	task automatic expect_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic send_cmd(input host_cmd_t cmd);
		@(negedge i_CLK);
		i_uart_data_rx = {cmd, 8'h00}; // command in the upper byte
		i_uart_data_rx_valid = 1'b1;
		@(negedge i_CLK);
		i_uart_data_rx_valid = 1'b0;
	endtask

	// ==========================================================
	// clock, watchdog, chip models, frame compare
	// ==========================================================
	initial begin
		i_CLK = 1'b0;
		forever #10 i_CLK = ~i_CLK;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge i_CLK);
		abort_run($sformatf("timeout: run still going after %0d cycles", LIMIT_CYCLES));
	end

	// mpr121 bus controller, 3 busy cycles per access
	always @(negedge i_CLK) begin
		if (mpr_busy_cnt > 0) begin
			mpr_busy_cnt = mpr_busy_cnt - 1;
			if (mpr_busy_cnt == 0) i_mpr121_busy = 1'b0;
		end
		if (o_mpr121_write_enable) begin
			mpr_log.push_back({o_mpr121_reg_addr, o_mpr121_data_in});
			i_mpr121_fail = 1'b0;
			i_mpr121_busy = 1'b1;
			mpr_busy_cnt = 3;
		end else if (o_mpr121_read_enable) begin
			i_mpr121_data_out = (o_mpr121_reg_addr == 8'h01) ? ST1 : ST0;
			if (o_mpr121_reg_addr == 8'h01) hi_reads = hi_reads + 1;
			i_mpr121_fail = fail_arm; // reported once busy drops
			i_mpr121_busy = 1'b1;
			mpr_busy_cnt = 3;
		end
	end

	// ads1292 bus controller, wreg log and sample stream
	always @(negedge i_CLK) begin
		if (ads_busy_cnt > 0) begin
			ads_busy_cnt = ads_busy_cnt - 1;
			if (ads_busy_cnt == 0) i_ads1292_busy = 1'b0;
		end
		case (o_ads1292_control)
			ADS_CB_WREG: begin
				ads_log.push_back({o_ads1292_reg_addr, o_ads1292_data_in});
				i_ads1292_busy = 1'b1;
				ads_busy_cnt = 2;
			end
			ADS_CB_RDATAC, ADS_CB_SDATAC: ads_last_cmd = o_ads1292_control;
			default: ;
		endcase
		if (o_ads1292_data_ack) begin
			i_ads1292_data_valid = 1'b0; // sample taken
			last_acked = i_ads1292_data_out;
			acked_count = acked_count + 1;
		end else if (!i_ads1292_data_valid && ads_offer.size() > 0) begin
			i_ads1292_data_out = ads_offer.pop_front();
			i_ads1292_data_valid = 1'b1; // held until ack
		end
	end

	// every released frame carries the newest acked sample
	always @(posedge i_CLK) begin
		if (!i_RST && o_uart_data_tx_valid) begin
			check_frame(o_uart_data_tx, expected_frame(last_acked, ST0, ST1));
			last_frame = o_uart_data_tx;
			frames_seen = frames_seen + 1;
		end
	end

	// ==========================================================
	// test sequence
	// ==========================================================
	initial begin
		sample_t s;
		int unsigned fb;
		int unsigned ab;
		int wb;

		i_RST = 1'b1;
		i_uart_data_rx = '0;
		i_uart_data_rx_valid = 1'b0;
		i_uart_data_tx_ready = 1'b1;
		i_mpr121_init_set = 1'b0;
		i_ads1292_init_set = 1'b0;
		fail_arm = 1'b0;
		lfsr = 16'd9892;
		repeat (3) @(negedge i_CLK);
		i_RST = 1'b0;

		// outputs quiet until the chips report init
		@(negedge i_CLK);
		expect_level(o_mpr121_write_enable, 1'b0, "mpr121 write enable");
		expect_level(o_mpr121_read_enable, 1'b0, "mpr121 read enable");
		expect_level(o_uart_data_tx_valid, 1'b0, "tx valid");
		expect_level(o_ads1292_data_ack, 1'b0, "ads1292 ack");
		expect_level(o_chip_set, 1'b0, "chip set");
		expect_level(o_run_set, 1'b0, "run set");
		expect_level(o_mpr121_error, 1'b0, "mpr121 error");
		check_ctrl(o_ads1292_control, ADS_CB_IDLE);
		repeat (4) @(negedge i_CLK);
		i_mpr121_init_set = 1'b1;
		i_ads1292_init_set = 1'b1;
		while (!o_chip_set) @(negedge i_CLK);
		if (mpr_log.size() != MPR_INIT_LEN) abort_run("MPR121 configuration write count is wrong");
		if (ads_log.size() != ADS_INIT_LEN) abort_run("ADS1292 configuration write count is wrong");
		foreach (mpr_log[i]) check_write(mpr_log[i], MPR_INIT_TABLE[i]);
		foreach (ads_log[i]) check_write(ads_log[i], ADS_INIT_TABLE[i]);

		// run: electrodes on, rdatac, then polling
		send_cmd(HOST_CMD_RUN);
		while (!o_run_set) @(negedge i_CLK);
		check_write(mpr_log[$], {8'h5E, 8'h8F});
		check_ctrl(ads_last_cmd, ADS_CB_RDATAC);
		while (hi_reads < 2) @(negedge i_CLK); // first round complete
		check_touch(o_mpr121_touch_status, {ST1[3:0], ST0});

		// stream with the host always ready
		ab = acked_count;
		for (int n = 0; n < N_SAMPLES; n++) begin
			draw_sample(s);
			ads_offer.push_back(s);
			fb = frames_seen;
			while (frames_seen == fb) @(negedge i_CLK);
			check_frame(last_frame, expected_frame(s, ST0, ST1));
		end
		if (acked_count != ab + N_SAMPLES) abort_run("not every streamed sample was acked");

		// host stalls, only the newest frame survives
		i_uart_data_tx_ready = 1'b0;
		ab = acked_count;
		fb = frames_seen;
		for (int n = 0; n < N_HELD; n++) begin
			draw_sample(s);
			ads_offer.push_back(s);
		end
		while (acked_count < ab + N_HELD) @(negedge i_CLK);
		if (frames_seen != fb) abort_run("frame released while tx ready was low");
		i_uart_data_tx_ready = 1'b1;
		while (frames_seen == fb) @(negedge i_CLK);
		check_frame(last_frame, expected_frame(s, ST0, ST1));
		repeat (10) @(negedge i_CLK);
		if (frames_seen != fb + 1) abort_run("more than one frame released after the stall");

		// stop: electrodes off, sdatac, stream quiet
		wb = mpr_log.size();
		send_cmd(HOST_CMD_STOP);
		while (mpr_log.size() == wb) @(negedge i_CLK); // ads side stops first
		check_write(mpr_log[$], {8'h5E, 8'h00});
		check_ctrl(ads_last_cmd, ADS_CB_SDATAC);
		expect_level(o_run_set, 1'b0, "run set after stop");
		fb = frames_seen;
		ab = acked_count;
		draw_sample(s);
		ads_offer.push_back(s); // stays offered, nobody takes it
		repeat (20) @(negedge i_CLK);
		if (frames_seen != fb || acked_count != ab) abort_run("sample streamed after stop");

		// run again, then a bus fail on a status read
		send_cmd(HOST_CMD_RUN);
		while (!o_run_set) @(negedge i_CLK);
		fail_arm = 1'b1;
		while (!o_mpr121_error) @(negedge i_CLK);

		// a clean write afterwards must not clear the flag
		fail_arm = 1'b0;
		wb = mpr_log.size();
		send_cmd(HOST_CMD_STOP);
		while (mpr_log.size() == wb) @(negedge i_CLK);
		repeat (10) @(negedge i_CLK);
		expect_level(o_mpr121_error, 1'b1, "mpr121 error after bus fail");

		repeat (4) @(negedge i_CLK);
		if (i_dut.u_chk.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
common/sensor_pkg.sv
common/sensor_ctrl_if.sv
logic/host_link.sv
logic/sensor_sequencer.sv
mpr121/mpr121_engine.sv
ads1292/ads1292_engine.sv
logic/sensor_core.sv
dv/sensor_core_chk.sv
dv/sensor_core_tb.sv

/* logic/host_link.sv */
`default_nettype none

module host_link (
	input wire i_CLK,
	input wire i_RST,
	input wire [15:0] i_rx_data, // cmd byte on top
	input wire i_rx_valid,
	input wire i_tx_ready,
	output sensor_pkg::tx_frame_t o_tx_data,
	output logic o_tx_valid,
	input wire sensor_pkg::sample_t i_sample,
	input wire i_sample_strobe,
	input wire sensor_pkg::touch_t i_touch,
	output logic o_run_mode
);
	import sensor_pkg::*;

	tx_frame_t r_frame; // newest frame not yet taken
	logic r_pending;

	// ==========================================================
	// command decode
	// ==========================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_run_mode <= 1'b0;
		end else if (i_rx_valid) begin
			case (i_rx_data[15:8])
				HOST_CMD_RUN: o_run_mode <= 1'b1;
				HOST_CMD_STOP: o_run_mode <= 1'b0;
				default: ; // unknown bytes dropped
			endcase
		end
	end

	// ==========================================================
	// sample frame
	// ==========================================================
	// marker, sample, 16 bit touch word, marker
	always_ff @(posedge i_CLK) begin
		if (i_sample_strobe) begin
			r_frame <= {FRAME_ADS_MARK, i_sample, 4'b0000, i_touch, FRAME_MPR_MARK};
		end
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_pending <= 1'b0;
		end else if (i_sample_strobe) begin
			r_pending <= 1'b1; // overwrite keeps only the newest
		end else if (i_tx_ready) begin
			r_pending <= 1'b0; // taken this cycle
		end
	end

	// offered only in a ready cycle, one beat per frame
	assign o_tx_valid = r_pending & i_tx_ready;
	assign o_tx_data = r_frame;

endmodule

`default_nettype wire

/* logic/sensor_core.sv */
`default_nettype none

module sensor_core #(
	parameter int unsigned POLL_GAP = 1 // mpr121 poll spacing
) (
	input wire i_CLK,
	input wire i_RST,
	// host uart
	input wire [15:0] i_uart_data_rx,
	input wire i_uart_data_rx_valid,
	input wire i_uart_data_tx_ready,
	output sensor_pkg::tx_frame_t o_uart_data_tx,
	output logic o_uart_data_tx_valid,
	// mpr121 bus controller
	input wire sensor_pkg::byte_t i_mpr121_data_out,
	output sensor_pkg::byte_t o_mpr121_reg_addr,
	output sensor_pkg::byte_t o_mpr121_data_in,
	output logic o_mpr121_write_enable,
	output logic o_mpr121_read_enable,
	input wire i_mpr121_init_set,
	input wire i_mpr121_busy,
	input wire i_mpr121_fail,
	output sensor_pkg::touch_t o_mpr121_touch_status,
	output logic o_mpr121_error,
	// ads1292 bus controller
	input wire sensor_pkg::sample_t i_ads1292_data_out,
	input wire i_ads1292_data_valid,
	output logic o_ads1292_data_ack,
	output sensor_pkg::ads_ctrl_t o_ads1292_control,
	output sensor_pkg::byte_t o_ads1292_reg_addr,
	output sensor_pkg::byte_t o_ads1292_data_in,
	input wire i_ads1292_init_set,
	input wire i_ads1292_busy,
	// system status
	output logic o_chip_set,
	output logic o_run_set
);
	import sensor_pkg::*;

	sample_t w_sample; // ads1292 to host link
	logic w_sample_strobe;
	logic w_run_mode;

	sensor_ctrl_if mpr_if ();
	sensor_ctrl_if ads_if ();

	host_link u_host_link (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_rx_data(i_uart_data_rx), .i_rx_valid(i_uart_data_rx_valid),
		.i_tx_ready(i_uart_data_tx_ready),
		.o_tx_data(o_uart_data_tx), .o_tx_valid(o_uart_data_tx_valid),
		.i_sample(w_sample), .i_sample_strobe(w_sample_strobe),
		.i_touch(o_mpr121_touch_status), // current status into every frame
		.o_run_mode(w_run_mode)
	);

	sensor_sequencer u_sequencer (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_mpr_init_set(i_mpr121_init_set), .i_ads_init_set(i_ads1292_init_set),
		.i_run_mode(w_run_mode),
		.mpr(mpr_if.seq), .ads(ads_if.seq),
		.o_chip_set(o_chip_set), .o_run_set(o_run_set)
	);

	mpr121_engine #(.POLL_GAP(POLL_GAP)) u_mpr121 (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.ctrl(mpr_if.engine),
		.i_data_out(i_mpr121_data_out), .i_busy(i_mpr121_busy), .i_fail(i_mpr121_fail),
		.o_reg_addr(o_mpr121_reg_addr), .o_data_in(o_mpr121_data_in),
		.o_write_enable(o_mpr121_write_enable), .o_read_enable(o_mpr121_read_enable),
		.o_touch_status(o_mpr121_touch_status), .o_error(o_mpr121_error)
	);

	ads1292_engine u_ads1292 (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.ctrl(ads_if.engine),
		.i_data_out(i_ads1292_data_out), .i_data_valid(i_ads1292_data_valid),
		.i_busy(i_ads1292_busy),
		.o_data_ack(o_ads1292_data_ack), .o_control(o_ads1292_control),
		.o_reg_addr(o_ads1292_reg_addr), .o_data_in(o_ads1292_data_in),
		.o_sample(w_sample), .o_sample_strobe(w_sample_strobe)
	);

endmodule

`default_nettype wire

/* logic/sensor_sequencer.sv */
`default_nettype none

module sensor_sequencer (
	input wire i_CLK,
	input wire i_RST,
	input wire i_mpr_init_set,
	input wire i_ads_init_set,
	input wire i_run_mode,
	sensor_ctrl_if.seq mpr,
	sensor_ctrl_if.seq ads,
	output logic o_chip_set,
	output logic o_run_set
);
	import sensor_pkg::*;

	core_state_t r_state;

	// status, one cycle behind the engines
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_chip_set <= 1'b0;
			o_run_set <= 1'b0;
		end else begin
			o_chip_set <= mpr.chip_set_done & ads.chip_set_done;
			o_run_set <= mpr.run_set_done & ads.run_set_done;
		end
	end

	// ==========================================================
	// core fsm
	// ==========================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= CORE_ST_IDLE;
			mpr.chip_set <= 1'b0;
			ads.chip_set <= 1'b0;
			mpr.run_set <= 1'b0;
			ads.run_set <= 1'b0;
		end else begin
			case (r_state)
				CORE_ST_IDLE: r_state <= CORE_ST_WAIT_INIT;
				CORE_ST_WAIT_INIT: begin
					// bus controllers finish their own power-up first
					if (i_mpr_init_set & i_ads_init_set) r_state <= CORE_ST_CHIP_SET;
				end
				CORE_ST_CHIP_SET: begin
					mpr.chip_set <= !mpr.chip_set_done; // drop once done
					ads.chip_set <= !ads.chip_set_done;
					if (o_chip_set) r_state <= CORE_ST_STANDBY;
				end
				CORE_ST_STANDBY: begin
					mpr.run_set <= i_run_mode; // both chips together
					ads.run_set <= i_run_mode;
					if (i_run_mode & o_run_set) r_state <= CORE_ST_READING;
				end
				CORE_ST_READING: begin
					if (!i_run_mode) begin
						mpr.run_set <= 1'b0;
						ads.run_set <= 1'b0;
						r_state <= CORE_ST_STANDBY;
					end
				end
				default: r_state <= CORE_ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mpr121/mpr121_engine.sv */
`default_nettype none

module mpr121_engine #(
	parameter int unsigned POLL_GAP = 1 // idle cycles between rounds
) (
	input wire i_CLK,
	input wire i_RST,
	sensor_ctrl_if.engine ctrl,
	input wire sensor_pkg::byte_t i_data_out, // read data
	input wire i_busy,
	input wire i_fail,
	output sensor_pkg::byte_t o_reg_addr,
	output sensor_pkg::byte_t o_data_in,
	output logic o_write_enable,
	output logic o_read_enable,
	output sensor_pkg::touch_t o_touch_status,
	output logic o_error
);
	import sensor_pkg::*;

	mpr_state_t r_state;
	mpr_state_t r_ret; // resume point after an access
	logic [3:0] r_idx; // init table position
	logic [3:0] r_gap; // poll gap count
	logic r_read; // 1 = read access
	logic r_hi; // status 1 read in flight

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= MPR_ST_IDLE;
			r_ret <= MPR_ST_IDLE;
			r_idx <= '0;
			r_gap <= '0;
			r_read <= 1'b0;
			r_hi <= 1'b0;
			o_reg_addr <= '0;
			o_data_in <= '0;
			o_write_enable <= 1'b0;
			o_read_enable <= 1'b0;
			o_touch_status <= '0;
			o_error <= 1'b0;
			ctrl.chip_set_done <= 1'b0;
			ctrl.run_set_done <= 1'b0;
		end else begin
			case (r_state)
				MPR_ST_IDLE: begin
					if (ctrl.chip_set && !ctrl.chip_set_done) begin
						r_idx <= '0;
						r_state <= MPR_ST_SETTING;
					end else if (ctrl.run_set && !ctrl.run_set_done) begin
						r_state <= MPR_ST_RUN;
					end else if (!ctrl.run_set && ctrl.run_set_done) begin
						r_state <= MPR_ST_STOP; // stop after a failed poll
					end
				end

				// ==================================================
				// config table and electrode run / stop
				// ==================================================
				MPR_ST_SETTING: begin
					if (r_idx == 4'(MPR_INIT_LEN)) begin
						ctrl.chip_set_done <= 1'b1;
						r_state <= MPR_ST_IDLE;
					end else begin
						o_reg_addr <= MPR_INIT_TABLE[r_idx].addr;
						o_data_in <= MPR_INIT_TABLE[r_idx].data;
						r_read <= 1'b0;
						r_idx <= r_idx + 4'd1;
						r_ret <= MPR_ST_SETTING; // next entry
						r_state <= MPR_ST_ISSUE;
					end
				end
				MPR_ST_RUN: begin
					o_reg_addr <= MPR_ELE_CONFIG_REG;
					o_data_in <= MPR_ELE_RUN;
					r_read <= 1'b0;
					r_ret <= MPR_ST_RUN_DONE;
					r_state <= MPR_ST_ISSUE;
				end
				MPR_ST_RUN_DONE: begin
					ctrl.run_set_done <= 1'b1;
					r_state <= MPR_ST_POLL;
				end
				MPR_ST_STOP: begin
					o_reg_addr <= MPR_ELE_CONFIG_REG;
					o_data_in <= MPR_ELE_STOP; // electrodes off
					r_read <= 1'b0;
					r_ret <= MPR_ST_STOP_DONE;
					r_state <= MPR_ST_ISSUE;
				end
				MPR_ST_STOP_DONE: begin
					ctrl.run_set_done <= 1'b0;
					r_state <= MPR_ST_IDLE;
				end

				// ==================================================
				// status polling
				// ==================================================
				MPR_ST_POLL: begin
					if (!ctrl.run_set) begin
						r_state <= MPR_ST_STOP; // stop only at a round boundary
					end else begin
						o_reg_addr <= MPR_STATUS0_REG;
						r_read <= 1'b1;
						r_hi <= 1'b0;
						r_ret <= MPR_ST_POLL_HI;
						r_state <= MPR_ST_ISSUE;
					end
				end
				MPR_ST_POLL_HI: begin
					o_reg_addr <= MPR_STATUS1_REG;
					r_hi <= 1'b1;
					r_gap <= '0;
					r_ret <= MPR_ST_GAP;
					r_state <= MPR_ST_ISSUE;
				end
				MPR_ST_GAP: begin
					if (r_gap == 4'(POLL_GAP)) r_state <= MPR_ST_POLL;
					else r_gap <= r_gap + 4'd1;
				end

				// ==================================================
				// shared bus access
				// ==================================================
				MPR_ST_ISSUE: begin
					o_write_enable <= !r_read; // one-cycle pulse
					o_read_enable <= r_read;
					r_state <= MPR_ST_XFER;
				end
				MPR_ST_XFER: begin
					o_write_enable <= 1'b0;
					o_read_enable <= 1'b0;
					r_state <= MPR_ST_SKIP;
				end
				MPR_ST_SKIP: r_state <= MPR_ST_WAIT; // busy may still be stale
				MPR_ST_WAIT: begin
					if (!i_busy) begin
						if (i_fail) begin
							o_error <= 1'b1; // sticky
							r_state <= MPR_ST_IDLE;
						end else begin
							if (r_read && r_hi) o_touch_status[11:8] <= i_data_out[3:0];
							else if (r_read) o_touch_status[7:0] <= i_data_out;
							r_state <= r_ret;
						end
					end
				end
				default: r_state <= MPR_ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
